// ==== common/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address bus width
`define WORD_WIDTH 16

// General purpose registers
`define REG_COUNT 16

// Fetch, decode, execute, commit
`define PHASE_COUNT 4

// Byte addressed bus, one word per instruction
`define PC_STEP 2

`endif

// ==== common/isaPkg.sv ====
package isaPkg;

	// Instruction bits 15:14
	typedef enum logic [1:0] {
		GRP_ALU  = 2'd0,
		GRP_MEM  = 2'd1,
		GRP_JUMP = 2'd2,
		GRP_SYS  = 2'd3
	} group_t;

	// Bits 13:10 of an ALU instruction
	typedef enum logic [3:0] {
		OP_MOV = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR  = 4'd4,
		OP_XOR = 4'd5,
		OP_SL  = 4'd6,
		OP_SR  = 4'd7
	} aluOp_t;

	// Bits 9:8, operand source
	typedef enum logic [1:0] {
		MODE_REG_REG   = 2'd0,
		MODE_REG_U4    = 2'd1,
		MODE_REGB_U8   = 2'd2,
		MODE_REGA_U8RB = 2'd3
	} aluMode_t;

	// Bit 13 of a memory instruction
	typedef enum logic {
		MEM_LD = 1'b0,
		MEM_ST = 1'b1
	} memOp_t;

	// Bits 12:11 of a jump, sense bit is 13
	typedef enum logic [1:0] {
		COND_Z      = 2'd0,
		COND_C      = 2'd1,
		COND_S      = 2'd2,
		COND_ALWAYS = 2'd3
	} cond_t;

	// Implicit registers of the 8-bit immediate modes
	localparam logic [3:0] REG_RA = 4'd8;
	localparam logic [3:0] REG_RB = 4'd9;

endpackage

// ==== common/corePkg.sv ====
`include "core_defines.svh"

package corePkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;

	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

	// Z, C, S flag vector
	typedef logic [2:0] flags_t;

	localparam int FLAG_Z = 0;
	localparam int FLAG_C = 1;
	localparam int FLAG_S = 2;

	// One phase per clock, four per instruction
	typedef enum logic [$clog2(`PHASE_COUNT)-1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phase_t;

endpackage

// ==== design/phaseSequencer.sv ====
`timescale 1ns/10ps

module phaseSequencer (
	input  logic            CLK,
	input  logic            rstN,
	output corePkg::phase_t phase,
	output logic            fetch,
	output logic            decode,
	output logic            execute,
	output logic            commit
);
	import corePkg::*;

	phase_t nextPhase;

	always_comb begin
		case (phase)
			FETCH:   nextPhase = DECODE;
			DECODE:  nextPhase = EXECUTE;
			EXECUTE: nextPhase = COMMIT;
			default: nextPhase = FETCH;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= FETCH;
		end else begin
			phase <= nextPhase;
		end
	end

	// One-hot phase pulses
	assign fetch   = (phase == FETCH);
	assign decode  = (phase == DECODE);
	assign execute = (phase == EXECUTE);
	assign commit  = (phase == COMMIT);

endmodule

// ==== design/instructionDecoder.sv ====
`timescale 1ns/10ps

module instructionDecoder (
	input  corePkg::word_t    instr,
	input  corePkg::flags_t   flags,
	input  corePkg::phase_t   phase,
	output corePkg::regIdx_t  selA,
	output corePkg::regIdx_t  selB,
	output isaPkg::aluOp_t    aluOp,
	output isaPkg::aluMode_t  aluMode,
	output corePkg::word_t    imm,
	output logic              regWrite,
	output logic              flagWrite,
	output logic              memRead,
	output logic              memWrite,
	output logic              jumpTaken
);
	import corePkg::*;
	import isaPkg::*;

	group_t group;
	memOp_t memOp;
	cond_t  cond;
	logic   sense;
	logic   busPhase;
	logic   condMet;

	assign group   = group_t'(instr[15:14]);
	assign aluOp   = aluOp_t'(instr[13:10]);
	assign aluMode = aluMode_t'(instr[9:8]);
	assign memOp   = memOp_t'(instr[13]);
	assign cond    = cond_t'(instr[12:11]);
	assign sense   = instr[13];

	// Byte immediate modes work on RA or RB implicitly
	always_comb begin
		selA = instr[7:4];
		selB = instr[3:0];
		if (group == GRP_ALU && aluMode == MODE_REGB_U8) begin
			selA = REG_RB;
		end
		if (group == GRP_ALU && aluMode == MODE_REGA_U8RB) begin
			selA = REG_RA;
			selB = REG_RB;
		end
	end

	// Zero-extended, the ALU forms the RA.RBL concatenation
	assign imm = (aluMode == MODE_REG_U4) ? word_t'(instr[3:0]) : word_t'(instr[7:0]);

	assign busPhase  = (phase == EXECUTE) || (phase == COMMIT);
	assign memRead   = busPhase && (group == GRP_MEM) && (memOp == MEM_LD);
	assign memWrite  = busPhase && (group == GRP_MEM) && (memOp == MEM_ST);
	assign flagWrite = (phase == COMMIT) && (group == GRP_ALU);
	assign regWrite  = (phase == COMMIT) &&
		((group == GRP_ALU) || ((group == GRP_MEM) && (memOp == MEM_LD)));

	// Selected flag must match the sense bit
	always_comb begin
		case (cond)
			COND_Z:  condMet = (flags[FLAG_Z] == sense);
			COND_C:  condMet = (flags[FLAG_C] == sense);
			COND_S:  condMet = (flags[FLAG_S] == sense);
			default: condMet = 1'b1;
		endcase
	end

	assign jumpTaken = (group == GRP_JUMP) && condMet;

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module registerFile (
	input  logic             CLK,
	input  logic             rstN,
	input  corePkg::regIdx_t selA,
	input  corePkg::regIdx_t selB,
	input  logic             we,
	input  corePkg::word_t   wdata,
	output corePkg::word_t   rdataA,
	output corePkg::word_t   rdataB
);
	import corePkg::*;

	word_t regs [`REG_COUNT];

	// Destination is always the A select
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[selA] <= wdata;
		end
	end

	// Asynchronous read ports
	assign rdataA = regs[selA];
	assign rdataB = regs[selB];

endmodule

// ==== alu/alu.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module alu (
	input  logic             CLK,
	input  logic             rstN,
	input  corePkg::word_t   opA,
	input  corePkg::word_t   regB,
	input  corePkg::word_t   imm,
	input  isaPkg::aluOp_t   aluOp,
	input  isaPkg::aluMode_t aluMode,
	input  logic             flagWrite,
	output corePkg::word_t   result,
	output corePkg::flags_t  flags
);
	import corePkg::*;
	import isaPkg::*;

	word_t                opB;
	logic                 carry;
	logic [`WORD_WIDTH:0] sum;
	logic [`WORD_WIDTH:0] diff;

	// Immediate high byte over RB low byte in the RA mode
	always_comb begin
		case (aluMode)
			MODE_REG_REG:   opB = regB;
			MODE_REGA_U8RB: opB = {imm[7:0], regB[7:0]};
			default:        opB = imm;
		endcase
	end

	assign sum  = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};

	// Top bit of diff is the borrow
	always_comb begin
		carry = 1'b0;
		case (aluOp)
			OP_MOV: result = opB;
			OP_ADD: begin
				result = sum[`WORD_WIDTH-1:0];
				carry  = sum[`WORD_WIDTH];
			end
			OP_SUB: begin
				result = diff[`WORD_WIDTH-1:0];
				carry  = diff[`WORD_WIDTH];
			end
			OP_AND: result = opA & opB;
			OP_OR:  result = opA | opB;
			OP_XOR: result = opA ^ opB;
			OP_SL:  result = opA << opB[3:0];
			OP_SR:  result = opA >> opB[3:0];
			default: result = opB;
		endcase
	end

	// Flags change only on the commit of an ALU instruction
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			flags <= '0;
		end else if (flagWrite) begin
			flags[FLAG_Z] <= (result == '0);
			flags[FLAG_C] <= carry;
			flags[FLAG_S] <= result[`WORD_WIDTH-1];
		end
	end

endmodule

// ==== design/processorCore.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module processorCore (
	input  logic           CLK,
	input  logic           rstN,
	input  corePkg::word_t din,
	output corePkg::word_t addr,
	output corePkg::word_t dout,
	output logic           rdN,
	output logic           wrN,
	output logic           fetch,
	output logic           decode,
	output logic           execute,
	output logic           commit
);
	import corePkg::*;
	import isaPkg::*;

	word_t    pc;
	word_t    instr;
	phase_t   phase;
	regIdx_t  selA;
	regIdx_t  selB;
	aluOp_t   aluOp;
	aluMode_t aluMode;
	word_t    imm;
	word_t    rdataA;
	word_t    rdataB;
	word_t    aluResult;
	word_t    wdata;
	flags_t   flags;
	logic     regWrite;
	logic     flagWrite;
	logic     memRead;
	logic     memWrite;
	logic     jumpTaken;

	phaseSequencer i_seq (
		.CLK     (CLK),
		.rstN    (rstN),
		.phase   (phase),
		.fetch   (fetch),
		.decode  (decode),
		.execute (execute),
		.commit  (commit)
	);

	instructionDecoder i_dec (
		.instr     (instr),
		.flags     (flags),
		.phase     (phase),
		.selA      (selA),
		.selB      (selB),
		.aluOp     (aluOp),
		.aluMode   (aluMode),
		.imm       (imm),
		.regWrite  (regWrite),
		.flagWrite (flagWrite),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.jumpTaken (jumpTaken)
	);

	registerFile i_regs (
		.CLK    (CLK),
		.rstN   (rstN),
		.selA   (selA),
		.selB   (selB),
		.we     (regWrite),
		.wdata  (wdata),
		.rdataA (rdataA),
		.rdataB (rdataB)
	);

	alu i_alu (
		.CLK       (CLK),
		.rstN      (rstN),
		.opA       (rdataA),
		.regB      (rdataB),
		.imm       (imm),
		.aluOp     (aluOp),
		.aluMode   (aluMode),
		.flagWrite (flagWrite),
		.result    (aluResult),
		.flags     (flags)
	);

	// Jump target comes from register A
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= '0;
		end else if (commit) begin
			pc <= jumpTaken ? rdataA : pc + word_t'(`PC_STEP);
		end
	end

	// Memory answers during fetch, latched at the end of decode
	always_ff @(posedge CLK) begin
		if (decode) begin
			instr <= din;
		end
	end

	// Register B holds the data address for LD and ST
	assign addr  = (memRead || memWrite) ? rdataB : pc;
	assign dout  = rdataA;
	assign rdN   = !(fetch || decode || memRead);
	assign wrN   = !memWrite;
	assign wdata = memRead ? din : aluResult;

endmodule

// ==== tests/processorCore_properties.sv ====
`timescale 1ns/10ps

module processorCore_properties (
	input logic CLK,
	input logic rstN,
	input logic rdN,
	input logic wrN,
	input logic fetch,
	input logic decode,
	input logic execute,
	input logic commit
);

	onePhase: assert property (@(posedge CLK) disable iff (!rstN)
		$onehot({fetch, decode, execute, commit}))
		else $error("Phase pulses are not one-hot");

	// Fixed phase order
	afterFetch: assert property (@(posedge CLK) disable iff (!rstN) fetch |=> decode)
		else $error("Decode did not follow fetch");
	afterDecode: assert property (@(posedge CLK) disable iff (!rstN) decode |=> execute)
		else $error("Execute did not follow decode");
	afterExecute: assert property (@(posedge CLK) disable iff (!rstN) execute |=> commit)
		else $error("Commit did not follow execute");
	afterCommit: assert property (@(posedge CLK) disable iff (!rstN) commit |=> fetch)
		else $error("Fetch did not follow commit");

	strobesExclusive: assert property (@(posedge CLK) disable iff (!rstN) rdN || wrN)
		else $error("rdN and wrN low together");

	writeInDataPhase: assert property (@(posedge CLK) disable iff (!rstN)
		!wrN |-> (execute || commit))
		else $error("wrN low outside execute and commit");

endmodule

bind processorCore processorCore_properties i_props (
	.CLK     (CLK),
	.rstN    (rstN),
	.rdN     (rdN),
	.wrN     (wrN),
	.fetch   (fetch),
	.decode  (decode),
	.execute (execute),
	.commit  (commit)
);

// ==== tests/processorCoreTb.sv ====
`timescale 1ns/10ps

module processorCoreTb;
	import isaPkg::*;

	localparam int MEM_WORDS = 32768;
	localparam logic [15:0] SEED = 16'd39975;
	localparam logic [3:0] ADDR_REG = 4'd15;
	localparam logic [3:0] TARGET_REG = 4'd13;
	localparam logic [15:0] NOP_INS = {GRP_SYS, 14'h0000};

	logic CLK = 1'b0;
	logic rstN = 1'b0;
	logic [15:0] din;
	logic [15:0] addr;
	logic [15:0] dout;
	logic rdN;
	logic wrN;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;

	logic [15:0] mem [MEM_WORDS];
	logic [15:0] refMem [MEM_WORDS];
	logic [15:0] refRegs [16];
	// S, C, Z from high to low
	logic [2:0] refFlags;
	logic [15:0] refPc;
	logic [15:0] lfsr = SEED;
	logic [15:0] endAddr;
	logic expRd;
	logic expWr;
	logic [15:0] expAddr;
	logic [15:0] expData;
	int progLen = 0;
	int resetCycles = 0;
	int sinceFetch = 0;
	int fetchCount = 0;
	int storeCount = 0;
	bit progReady = 1'b0;

	processorCore i_dut (.*);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		if (resetCycles < 4) begin
			resetCycles <= resetCycles + 1;
		end else begin
			rstN <= 1'b1;
		end
	end

	// Combinational memory that takes stores in the middle of a phase
	assign din = rdN ? 16'h0000 : mem[addr[15:1]];

	always @(negedge CLK) begin
		if (!wrN) begin
			mem[addr[15:1]] = dout;
		end
	end

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] randBits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return value;
	endfunction

	function automatic logic [15:0] dataAddr();
		return 16'h8000 | (randBits(14) << 1);
	endfunction

	function automatic logic [15:0] aluIns(input logic [3:0] op, input logic [1:0] mode,
			input logic [7:0] low);
		return {GRP_ALU, op, mode, low};
	endfunction

	task automatic emit(input logic [15:0] ins);
		mem[15'(progLen)] = ins;
		progLen++;
	endtask

	// Any 16-bit constant via RB, then RA, then a register move
	task automatic loadConst(input logic [3:0] dst, input logic [15:0] value);
		emit(aluIns(OP_MOV, MODE_REGB_U8, value[7:0]));
		emit(aluIns(OP_MOV, MODE_REGA_U8RB, value[15:8]));
		emit(aluIns(OP_MOV, MODE_REG_REG, {dst, REG_RA}));
	endtask

	task automatic storeReg(input logic [3:0] src);
		loadConst(ADDR_REG, dataAddr());
		emit({GRP_MEM, MEM_ST, 5'b00000, src, ADDR_REG});
	endtask

	function automatic void refStep(input logic [15:0] ins, output logic [15:0] nextPc,
			output logic rd, output logic wr, output logic [15:0] memAddr,
			output logic [15:0] wrData);
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] dst;
		logic [15:0] opA;
		logic [15:0] opB;
		logic [15:0] res;
		logic carry;
		logic taken;
		ra = ins[7:4];
		rb = ins[3:0];
		dst = ra;
		opA = refRegs[ra];
		nextPc = refPc + 16'd2;
		rd = 1'b0;
		wr = 1'b0;
		memAddr = refRegs[rb];
		wrData = refRegs[ra];
		carry = 1'b0;
		case (ins[15:14])
			2'd0: begin
				case (ins[9:8])
					2'd0: opB = refRegs[rb];
					2'd1: opB = {12'h000, ins[3:0]};
					2'd2: begin
						dst = 4'd9;
						opA = refRegs[9];
						opB = {8'h00, ins[7:0]};
					end
					default: begin
						dst = 4'd8;
						opA = refRegs[8];
						opB = {ins[7:0], refRegs[9][7:0]};
					end
				endcase
				case (ins[13:10])
					4'd0: res = opB;
					4'd1: {carry, res} = {1'b0, opA} + {1'b0, opB};
					4'd2: begin
						res = opA - opB;
						carry = opA < opB;
					end
					4'd3: res = opA & opB;
					4'd4: res = opA | opB;
					4'd5: res = opA ^ opB;
					4'd6: res = opA << opB[3:0];
					default: res = opA >> opB[3:0];
				endcase
				refRegs[dst] = res;
				refFlags = {res[15], carry, res == 16'h0000};
			end
			2'd1: begin
				if (ins[13]) begin
					wr = 1'b1;
					refMem[refRegs[rb][15:1]] = refRegs[ra];
				end else begin
					rd = 1'b1;
					refRegs[ra] = refMem[refRegs[rb][15:1]];
				end
			end
			2'd2: begin
				case (ins[12:11])
					2'd0: taken = refFlags[0] == ins[13];
					2'd1: taken = refFlags[1] == ins[13];
					2'd2: taken = refFlags[2] == ins[13];
					default: taken = 1'b1;
				endcase
				if (taken) begin
					nextPc = refRegs[ra];
				end
			end
			default: begin
			end
		endcase
	endfunction

	task automatic checkEq(input logic [15:0] actual, input logic [15:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Test failures found");
			$fatal(1, "Stopping at the first error");
		end
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[15'(i)] = 16'(i * 40503) ^ 16'h3C5A;
		end
		// Every ALU operation in register to register mode
		for (int round = 0; round < 2; round++) begin
			for (int op = 0; op < 8; op++) begin
				loadConst(4'd1, randBits(16));
				loadConst(4'd2, randBits(16));
				emit(aluIns(4'(op), MODE_REG_REG, {4'd1, 4'd2}));
				storeReg(4'd1);
			end
		end
		// The three immediate modes
		for (int i = 0; i < 4; i++) begin
			loadConst(4'd3, randBits(16));
			emit(aluIns(4'(randBits(3)), MODE_REG_U4, {4'd3, 4'(randBits(4))}));
			storeReg(4'd3);
			emit(aluIns(4'(randBits(3)), MODE_REGB_U8, 8'(randBits(8))));
			emit(aluIns(OP_MOV, MODE_REG_REG, {4'd4, REG_RB}));
			storeReg(4'd4);
			emit(aluIns(OP_MOV, MODE_REGB_U8, 8'(randBits(8))));
			emit(aluIns(4'(randBits(3)), MODE_REGA_U8RB, 8'(randBits(8))));
			emit(aluIns(OP_MOV, MODE_REG_REG, {4'd4, REG_RA}));
			storeReg(4'd4);
		end
		// Load a word and write it back elsewhere
		for (int i = 0; i < 4; i++) begin
			loadConst(ADDR_REG, dataAddr());
			emit({GRP_MEM, MEM_LD, 5'b00000, 4'd6, ADDR_REG});
			storeReg(4'd6);
		end
		// Taken jump skips the NOP right after it
		for (int round = 0; round < 2; round++) begin
			for (int c = 0; c < 8; c++) begin
				a = randBits(16);
				b = (randBits(1) != 0) ? a : randBits(16);
				loadConst(4'd1, a);
				loadConst(4'd2, b);
				loadConst(TARGET_REG, 16'(progLen * 2 + 12));
				emit(aluIns((randBits(1) != 0) ? OP_SUB : OP_ADD, MODE_REG_REG, {4'd1, 4'd2}));
				emit({GRP_JUMP, c[0], 2'(c >> 1), 3'b000, TARGET_REG, 4'b0000});
				emit(NOP_INS);
			end
		end
		emit(NOP_INS);
		emit(NOP_INS);
		endAddr = 16'(progLen * 2);
		emit(NOP_INS);
		for (int i = 0; i < MEM_WORDS; i++) begin
			refMem[15'(i)] = mem[15'(i)];
		end
		for (int r = 0; r < 16; r++) begin
			refRegs[r] = 16'h0000;
		end
		refFlags = 3'b000;
		refPc = 16'h0000;
		progReady = 1'b1;
	end

	always @(negedge CLK) begin
		logic [15:0] nextPc;
		logic atEnd;
		atEnd = 1'b0;
		if (!rstN) begin
			checkEq(16'(wrN), 16'd1, "wrN during reset");
			checkEq(addr, 16'h0000, "addr during reset");
			checkEq(16'({fetch, decode, execute, commit}), 16'b1000,
				"phase pulses during reset");
		end else begin
			// Fetch, decode, execute and commit in turn after each fetch
			checkEq(16'({fetch, decode, execute, commit}), 16'(4'b1000 >> (sinceFetch % 4)),
				"phase pulses");
			if (fetch) begin
				if (fetchCount > 0) begin
					checkEq(16'(sinceFetch), 16'd4, "cycles between fetches");
				end
				sinceFetch = 0;
				fetchCount++;
				checkEq(addr, refPc, "fetch address");
				checkEq(16'(rdN), 16'd0, "rdN during fetch");
				checkEq(16'(wrN), 16'd1, "wrN during fetch");
				if (refPc == endAddr) begin
					atEnd = 1'b1;
				end else begin
					refStep(refMem[refPc[15:1]], nextPc, expRd, expWr, expAddr, expData);
					refPc = nextPc;
				end
			end
			if (execute || commit) begin
				checkEq(16'(rdN), 16'(!expRd), "rdN in a data phase");
				checkEq(16'(wrN), 16'(!expWr), "wrN in a data phase");
				if (expRd || expWr) begin
					checkEq(addr, expAddr, "data address");
				end
				if (expWr) begin
					checkEq(dout, expData, "store data");
				end
				if (execute && expWr) begin
					storeCount++;
				end
			end
			sinceFetch++;
			if (atEnd) begin
				if (storeCount > 0) begin
					$display("All tests passed!");
					$finish;
				end else begin
					$display("The program ended without a single store");
					$display("Test failures found");
					$fatal(1, "No store was checked");
				end
			end
		end
	end

	// Four cycles per instruction plus slack for reset
	initial begin
		wait (progReady);
		#((progLen + 10) * 4 * 100);
		$display("Watchdog expired before the program reached its end");
		$display("Test failures found");
		$fatal(1, "Run took too long");
	end

endmodule

// ==== processorCore.f ====
+incdir+common
common/isaPkg.sv
common/corePkg.sv
design/phaseSequencer.sv
design/instructionDecoder.sv
design/registerFile.sv
alu/alu.sv
design/processorCore.sv
tests/processorCore_properties.sv
tests/processorCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module processorCoreTb -f processorCore.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qF "All tests passed!" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
